/* rtl/rv32i_pkg.sv */
package rv32i_pkg;

    // Architectural data word
    typedef logic [31:0] word_t;

    // ALU operations for the register-register and register-immediate forms
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    // Compare operations, encoded like the branch funct3 field
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    // Operand source select, the meaning depends on the operand slot
    typedef logic [1:0] op_sel_t;

    // Operand 1 sources
    localparam op_sel_t OP1_RS1  = 2'b00;
    localparam op_sel_t OP1_IMM  = 2'b01;
    localparam op_sel_t OP1_PC   = 2'b11;

    // Operand 2 sources
    // zero is used for the imm + 0 form of lui
    localparam op_sel_t OP2_RS2  = 2'b00;
    localparam op_sel_t OP2_ZERO = 2'b01;
    localparam op_sel_t OP2_IMM  = 2'b11;

endpackage

/* rtl/ooo_pkg.sv */
package ooo_pkg;

    // Physical register file size and tag
    localparam int unsigned NUM_PHYS_REGS = 64;

    typedef logic [5:0] phys_tag_t;

    // ROB index, passed through the FU untouched
    typedef logic [4:0] rob_id_t;

    // One entry issued from a reservation station
    typedef struct packed {
        logic               valid;
        rob_id_t            rob_id;
        phys_tag_t          ps1;
        phys_tag_t          ps2;
        phys_tag_t          pd;
        rv32i_pkg::word_t   pc;
        rv32i_pkg::word_t   imm;
        rv32i_pkg::op_sel_t op1_sel;
        rv32i_pkg::op_sel_t op2_sel;
        rv32i_pkg::alu_op_t alu_op;
        rv32i_pkg::cmp_op_t cmp_op;
        logic               alu_en;
        logic               is_branch;
        logic               writes_rd;
    } fu_input_t;

    // Register file answer for both source tags
    typedef struct packed {
        rv32i_pkg::word_t rs1_value;
        rv32i_pkg::word_t rs2_value;
    } reg_response_t;

    // A single register file write
    typedef struct packed {
        logic             valid;
        phys_tag_t        tag;
        rv32i_pkg::word_t data;
    } reg_write_t;

    // Registered FU result
    // rd_wdata and the rs*_rdata fields form the operand trace
    typedef struct packed {
        logic             valid;
        rob_id_t          rob_id;
        phys_tag_t        pd;
        logic             writes_rd;
        rv32i_pkg::word_t register_value;
        rv32i_pkg::word_t rd_wdata;
        logic             branch_taken;
        rv32i_pkg::word_t rs1_rdata;
        rv32i_pkg::word_t rs2_rdata;
    } fu_output_t;

endpackage

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu (
    input  rv32i_pkg::alu_op_t aluop,
    input  logic [31:0]        a,
    input  logic [31:0]        b,
    output logic [31:0]        f
);
    import rv32i_pkg::*;

    logic [4:0] shamt;

    // Shift amount comes from the low five bits only
    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'd0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $unsigned($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            // Unused codes produce zero
            default:  f = '0;
        endcase
    end

endmodule

/* rtl/cmp.sv */
`timescale 1ns/100ps

module cmp (
    input  rv32i_pkg::cmp_op_t cmpop,
    input  logic [31:0]        a,
    input  logic [31:0]        b,
    output logic               br_en
);
    import rv32i_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // slt and sltu are issued with blt and bltu here
    always_comb begin
        case (cmpop)
            cmp_beq:  br_en = (a == b);
            cmp_bne:  br_en = (a != b);
            cmp_blt:  br_en = lt_signed;
            cmp_bge:  br_en = !lt_signed;
            cmp_bltu: br_en = lt_unsigned;
            cmp_bgeu: br_en = !lt_unsigned;
            default:  br_en = 1'b0;
        endcase
    end

endmodule

/* rtl/phys_regfile.sv */
`timescale 1ns/100ps

module phys_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ooo_pkg::phys_tag_t    ps1,
    input  ooo_pkg::phys_tag_t    ps2,
    input  ooo_pkg::reg_write_t   wb,
    input  ooo_pkg::reg_write_t   load_wr,
    output ooo_pkg::reg_response_t rd_data
);
    import ooo_pkg::*;

    logic [31:0] regs [NUM_PHYS_REGS];

    logic wb_we;
    logic load_we;

    // Tag 0 is hardwired, so writes to it are dropped
    assign wb_we   = wb.valid && (wb.tag != '0);
    assign load_we = load_wr.valid && (load_wr.tag != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (load_we) begin
                regs[load_wr.tag] <= load_wr.data;
            end
            // Last assignment wins, so writeback beats the loader on a collision
            if (wb_we) begin
                regs[wb.tag] <= wb.data;
            end
        end
    end

    // Asynchronous reads, no bypass of the write in the same cycle
    always_comb begin
        if (ps1 == '0) begin
            rd_data.rs1_value = '0;
        end else begin
            rd_data.rs1_value = regs[ps1];
        end

        if (ps2 == '0) begin
            rd_data.rs2_value = '0;
        end else begin
            rd_data.rs2_value = regs[ps2];
        end
    end

endmodule

/* rtl/fu_wrapper.sv */
`timescale 1ns/100ps

module fu_wrapper (
    input  logic                   clk,
    input  logic                   arst_n,
    input  ooo_pkg::fu_input_t     issue,
    input  logic                   flush,
    input  ooo_pkg::reg_response_t reg_data,
    output ooo_pkg::phys_tag_t     ps1,
    output ooo_pkg::phys_tag_t     ps2,
    output ooo_pkg::fu_output_t    result
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    fu_input_t  entry;
    fu_output_t next_result;

    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    logic [31:0] alu_res;
    logic        cmp_res;

    // A flushed entry never reaches the units
    assign entry = flush ? '0 : issue;

    assign ps1 = entry.ps1;
    assign ps2 = entry.ps2;

    // Operand select
    always_comb begin
        case (entry.op1_sel)
            OP1_RS1: alu_a = reg_data.rs1_value;
            OP1_IMM: alu_a = entry.imm;
            OP1_PC:  alu_a = entry.pc;
            default: alu_a = '0;
        endcase

        case (entry.op2_sel)
            OP2_RS2:  alu_b = reg_data.rs2_value;
            OP2_ZERO: alu_b = '0;
            OP2_IMM:  alu_b = entry.imm;
            default:  alu_b = '0;
        endcase
    end

    // Branches compare rs1 against rs2 while the ALU forms pc + imm
    always_comb begin
        if (entry.is_branch) begin
            cmp_a = reg_data.rs1_value;
            cmp_b = reg_data.rs2_value;
        end else begin
            cmp_a = alu_a;
            cmp_b = alu_b;
        end
    end

    alu alu_i (
        .aluop (entry.alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_res)
    );

    cmp cmp_i (
        .cmpop (entry.cmp_op),
        .a     (cmp_a),
        .b     (cmp_b),
        .br_en (cmp_res)
    );

    // Result of the entry now in flight
    always_comb begin
        next_result = '0;
        if (entry.valid) begin
            next_result.valid        = 1'b1;
            next_result.rob_id       = entry.rob_id;
            next_result.pd           = entry.pd;
            next_result.branch_taken = cmp_res;
            next_result.rs1_rdata    = reg_data.rs1_value;
            next_result.rs2_rdata    = reg_data.rs2_value;

            if (entry.is_branch) begin
                // target only, nothing goes to rd
                next_result.register_value = alu_res;
                next_result.rd_wdata       = '0;
                next_result.writes_rd      = 1'b0;
            end else if (!entry.alu_en) begin
                next_result.register_value = {31'd0, cmp_res};
                next_result.rd_wdata       = {31'd0, cmp_res};
                next_result.writes_rd      = entry.writes_rd;
            end else begin
                next_result.register_value = alu_res;
                next_result.rd_wdata       = alu_res;
                next_result.writes_rd      = entry.writes_rd;
            end
        end
    end

    // Flush already zeroes the entry, so the next edge loads an empty result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result <= next_result;
        end
    end

endmodule

/* rtl/int_exec_top.sv */
`timescale 1ns/100ps

module int_exec_top (
    input  logic                clk,
    input  logic                arst_n,
    input  ooo_pkg::fu_input_t  issue,
    input  logic                flush,
    input  ooo_pkg::reg_write_t load_wr,
    output ooo_pkg::fu_output_t result
);
    import ooo_pkg::*;

    phys_tag_t     ps1;
    phys_tag_t     ps2;
    reg_response_t reg_data;
    reg_write_t    wb;

    // Writeback straight from the result register
    // branches never set writes_rd
    assign wb.valid = result.valid && result.writes_rd;
    assign wb.tag   = result.pd;
    assign wb.data  = result.register_value;

    phys_regfile regfile_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .ps1     (ps1),
        .ps2     (ps2),
        .wb      (wb),
        .load_wr (load_wr),
        .rd_data (reg_data)
    );

    fu_wrapper fu_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .issue    (issue),
        .flush    (flush),
        .reg_data (reg_data),
        .ps1      (ps1),
        .ps2      (ps2),
        .result   (result)
    );

endmodule

/* test/int_exec_props.sv */
`timescale 1ns/100ps

module int_exec_props (
    input logic                clk,
    input logic                arst_n,
    input ooo_pkg::fu_input_t  issue,
    input logic                flush,
    input ooo_pkg::fu_output_t result
);
    int unsigned fail_count = 0;

    // The output register stays empty while reset is held
    reset_idle: assert property (@(posedge clk) !arst_n |-> !result.valid)
        else begin
            fail_count++;
            $error("result valid while reset is asserted");
        end

    flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> (result == '0))
        else begin
            fail_count++;
            $error("result not empty on the cycle after a flush");
        end

    // Branch targets must never reach rd
    branch_no_rd: assert property (@(posedge clk) disable iff (!arst_n)
        (issue.valid && issue.is_branch && !flush)
            |=> (result.rd_wdata == '0 && !result.writes_rd))
        else begin
            fail_count++;
            $error("branch result carries rd data or writes_rd");
        end

endmodule

/* test/int_exec_checker.sv */
`timescale 1ns/100ps

module int_exec_checker (
    input logic                clk,
    input logic                arst_n,
    input ooo_pkg::fu_input_t  issue,
    input logic                flush,
    input ooo_pkg::reg_write_t load_wr,
    input ooo_pkg::fu_output_t result
);
    import rv32i_pkg::*;
    import ooo_pkg::*;

    logic [31:0] shadow [NUM_PHYS_REGS];
    fu_output_t  expected;
    reg_write_t  load_seen;
    reg_write_t  wb_pending;
    logic        in_reset = 1'b1;
    logic        have_exp = 1'b0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;

    function automatic logic [31:0] shadow_value(phys_tag_t tag);
        return (tag == '0) ? 32'd0 : shadow[tag];
    endfunction

    // Signed order by flipping the sign bits
    function automatic logic signed_less(logic [31:0] x, logic [31:0] y);
        return {~x[31], x[30:0]} < {~y[31], y[30:0]};
    endfunction

    task automatic write_shadow(reg_write_t w);
        if (w.valid && w.tag != '0) begin
            shadow[w.tag] = w.data;
        end
    endtask

    function automatic fu_output_t model_result(fu_input_t e, logic fl,
                                                logic [31:0] r1, logic [31:0] r2);
        fu_output_t  o;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] x;
        logic [31:0] y;
        logic        c;
        o = '0;
        if (fl || !e.valid) begin
            return o;
        end
        a = (e.op1_sel == OP1_PC) ? e.pc : (e.op1_sel == OP1_IMM) ? e.imm : r1;
        b = (e.op2_sel == OP2_IMM) ? e.imm : (e.op2_sel == OP2_ZERO) ? 32'd0 : r2;
        case (e.alu_op)
            alu_add:  v = a + b;
            alu_sub:  v = a - b;
            alu_sll:  v = a << b[4:0];
            alu_slt:  v = signed_less(a, b) ? 32'd1 : 32'd0;
            alu_sltu: v = (a < b) ? 32'd1 : 32'd0;
            alu_xor:  v = a ^ b;
            alu_srl:  v = a >> b[4:0];
            // Logical shift with the vacated bits filled from the sign
            alu_sra:  v = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            alu_or:   v = a | b;
            default:  v = a & b;
        endcase
        x = e.is_branch ? r1 : a;
        y = e.is_branch ? r2 : b;
        case (e.cmp_op)
            cmp_beq:  c = (x == y);
            cmp_bne:  c = (x != y);
            cmp_blt:  c = signed_less(x, y);
            cmp_bge:  c = !signed_less(x, y);
            cmp_bltu: c = (x < y);
            default:  c = !(x < y);
        endcase
        o.valid        = 1'b1;
        o.rob_id       = e.rob_id;
        o.pd           = e.pd;
        o.branch_taken = c;
        o.rs1_rdata    = r1;
        o.rs2_rdata    = r2;
        if (e.is_branch) begin
            o.register_value = v;
        end else if (!e.alu_en) begin
            o.register_value = {31'd0, c};
            o.rd_wdata       = {31'd0, c};
            o.writes_rd      = e.writes_rd;
        end else begin
            o.register_value = v;
            o.rd_wdata       = v;
            o.writes_rd      = e.writes_rd;
        end
        return o;
    endfunction

    // Inputs are stable here, the register file has not yet seen this edge
    always @(posedge clk) begin
        in_reset = !arst_n;
        if (arst_n) begin
            expected  = model_result(issue, flush, shadow_value(issue.ps1),
                                     shadow_value(issue.ps2));
            load_seen = load_wr;
            have_exp  = 1'b1;
        end else begin
            have_exp = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (in_reset) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                shadow[i] = '0;
            end
            wb_pending = '0;
            if (result !== '0) begin
                error_count++;
                $display("Error at %0t ns: result not cleared during reset", $time);
            end
        end else if (have_exp) begin
            // Writes of the last edge, writeback last so it wins a collision
            write_shadow(load_seen);
            write_shadow(wb_pending);
            check_count++;
            if (result !== expected) begin
                error_count++;
                $display("Error at %0t ns: result mismatch for pd %0d, got %h, expected %h",
                         $time, expected.pd, result, expected);
            end
            wb_pending.valid = expected.valid && expected.writes_rd;
            wb_pending.tag   = expected.pd;
            wb_pending.data  = expected.register_value;
        end
    end

endmodule

/* test/int_exec_tb.sv */
`timescale 1ns/100ps

module int_exec_tb;
    import rv32i_pkg::*;
    import ooo_pkg::*;

    localparam int N_PRELOAD    = NUM_PHYS_REGS - 1;
    localparam int N_RANDOM     = 400;
    localparam int N_DIRECTED   = 12;
    localparam int N_DRAIN      = 4;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 4;
    // Twice the planned run, plus reset
    localparam int TIMEOUT_NS   = (N_PRELOAD + N_RANDOM + N_DIRECTED + N_DRAIN) * CLK_PERIOD * 2
                                  + RESET_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        arst_n;
    fu_input_t   issue;
    logic        flush;
    reg_write_t  load_wr;
    fu_output_t  result;
    logic [31:0] rng_state = 32'h5b70_5c8b;

    int_exec_top dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .flush   (flush),
        .load_wr (load_wr),
        .result  (result)
    );

    int_exec_checker chk_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .flush   (flush),
        .load_wr (load_wr),
        .result  (result)
    );

    bind fu_wrapper int_exec_props props_i (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .flush  (flush),
        .result (result)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic fu_input_t random_entry();
        fu_input_t   e;
        logic [31:0] r;
        e = '0;
        e.valid  = 1'b1;
        r = next_rand();
        e.rob_id = r[4:0];
        // Nonzero tags only
        e.ps1    = 6'(1 + r[15:8] % 63);
        e.ps2    = 6'(1 + r[23:16] % 63);
        e.pd     = 6'(1 + r[31:24] % 63);
        r = next_rand();
        e.pc     = {r[31:2], 2'b00};
        e.imm    = next_rand();
        r = next_rand();
        case (r[1:0])
            2'd0:    e.op1_sel = OP1_RS1;
            2'd1:    e.op1_sel = OP1_IMM;
            default: e.op1_sel = OP1_PC;
        endcase
        case (r[3:2])
            2'd0:    e.op2_sel = OP2_RS2;
            2'd1:    e.op2_sel = OP2_ZERO;
            default: e.op2_sel = OP2_IMM;
        endcase
        e.alu_op    = alu_op_t'(4'(r[7:4] % 10));
        e.cmp_op    = r[10] ? cmp_op_t'({1'b1, r[9:8]}) : cmp_op_t'({2'b00, r[8]});
        e.alu_en    = (r[13:12] != 2'b00);
        e.is_branch = (r[15:14] == 2'b00);
        e.writes_rd = r[16] | r[17];
        // Branch target is pc + imm
        if (e.is_branch) begin
            e.op1_sel   = OP1_PC;
            e.op2_sel   = OP2_IMM;
            e.alu_op    = alu_add;
        end
        return e;
    endfunction

    function automatic fu_input_t alu_entry(alu_op_t op, op_sel_t s1, op_sel_t s2,
                                            phys_tag_t t1, phys_tag_t t2, phys_tag_t td,
                                            logic [31:0] imm);
        fu_input_t e;
        e = '0;
        e.valid     = 1'b1;
        e.rob_id    = td[4:0];
        e.ps1       = t1;
        e.ps2       = t2;
        e.pd        = td;
        e.pc        = 32'h0000_2000;
        e.imm       = imm;
        e.op1_sel   = s1;
        e.op2_sel   = s2;
        e.alu_op    = op;
        e.cmp_op    = cmp_beq;
        e.alu_en    = 1'b1;
        e.writes_rd = 1'b1;
        return e;
    endfunction

    task automatic drive_cycle(fu_input_t e, logic fl, reg_write_t lw);
        @(negedge clk);
        issue   = e;
        flush   = fl;
        load_wr = lw;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        fu_input_t   e;
        reg_write_t  lw;
        logic [31:0] r;
        int unsigned errors;
        arst_n  = 1'b0;
        issue   = '0;
        flush   = 1'b0;
        load_wr = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        // Preload every nonzero register
        for (int t = 1; t < NUM_PHYS_REGS; t++) begin
            lw.valid = 1'b1;
            lw.tag   = 6'(t);
            lw.data  = next_rand();
            drive_cycle('0, 1'b0, lw);
        end

        // Random traffic with idle slots, flushes and some loader writes
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = next_rand();
            lw = '0;
            if (i % 8 == 7) begin
                e = '0;
            end else begin
                e = random_entry();
            end
            if (r[2:0] == 3'd0) begin
                lw.valid = 1'b1;
                lw.tag   = 6'(1 + r[15:8] % 63);
                lw.data  = next_rand();
            end
            drive_cycle(e, r[7:4] == 4'd0, lw);
        end

        // Directed block around tag 0
        lw       = '0;
        lw.valid = 1'b1;
        lw.data  = 32'hdead_beef;
        drive_cycle('0, 1'b0, lw);
        lw = '0;
        drive_cycle(alu_entry(alu_add, OP1_RS1, OP2_RS2, 6'd0, 6'd0, 6'd10, '0), 1'b0, lw);
        drive_cycle(alu_entry(alu_add, OP1_IMM, OP2_ZERO, 6'd0, 6'd0, 6'd0, 32'h1234_5000),
                    1'b0, lw);
        drive_cycle(alu_entry(alu_sub, OP1_RS1, OP2_RS2, 6'd10, 6'd0, 6'd11, '0), 1'b0, lw);
        drive_cycle(alu_entry(alu_or, OP1_RS1, OP2_RS2, 6'd0, 6'd0, 6'd12, '0), 1'b0, lw);
        e = alu_entry(alu_add, OP1_RS1, OP2_RS2, 6'd20, 6'd0, 6'd13, '0);
        e.alu_en = 1'b0;
        e.cmp_op = cmp_blt;
        drive_cycle(e, 1'b0, lw);
        drive_cycle('0, 1'b0, lw);
        drive_cycle(alu_entry(alu_add, OP1_RS1, OP2_RS2, 6'd13, 6'd0, 6'd14, '0), 1'b0, lw);
        e = alu_entry(alu_add, OP1_PC, OP2_IMM, 6'd0, 6'd0, 6'd15, 32'h0000_0040);
        e.is_branch = 1'b1;
        e.writes_rd = 1'b0;
        drive_cycle(e, 1'b0, lw);
        e.ps2    = 6'd21;
        e.cmp_op = cmp_bltu;
        drive_cycle(e, 1'b0, lw);
        drive_cycle(alu_entry(alu_xor, OP1_RS1, OP2_IMM, 6'd0, 6'd0, 6'd0, 32'hffff_0000),
                    1'b1, lw);
        drive_cycle(alu_entry(alu_add, OP1_PC, OP2_IMM, 6'd0, 6'd0, 6'd16, 32'h0000_0800),
                    1'b0, lw);
        repeat (N_DRAIN) drive_cycle('0, 1'b0, lw);

        @(posedge clk);
        errors = chk_i.error_count + dut_i.fu_i.props_i.fail_count;
        $display("Checked %0d results: %0d mismatches, %0d assertion failures",
                 chk_i.check_count, chk_i.error_count, dut_i.fu_i.props_i.fail_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/rv32i_pkg.sv
rtl/ooo_pkg.sv
rtl/alu.sv
rtl/cmp.sv
rtl/phys_regfile.sv
rtl/fu_wrapper.sv
rtl/int_exec_top.sv
test/int_exec_props.sv
test/int_exec_checker.sv
test/int_exec_tb.sv

/* Makefile */
BIN  := obj_dir/Vint_exec_tb
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module int_exec_tb -Mdir obj_dir -f flist.f

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED"

clean:
	rm -rf obj_dir
